// ==== flist.f ====
+incdir+source
source/priv_types_pkg.sv
source/priv_irq_capture.sv
source/priv_trap_handler.sv
source/priv_csr_file.sv
source/priv_unit.sv
verif/priv_unit_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the trap unit testbench with Verilator.
# The exit status is that of the simulation, non-zero on any failure.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
    -f flist.f \
    --top-module priv_unit_tb \
    --Mdir obj_dir \
    -o priv_unit_sim
build_status=$?
if [ "$build_status" -ne 0 ]; then
    echo "build failed with status $build_status"
    exit "$build_status"
fi

./obj_dir/priv_unit_sim
sim_status=$?
if [ "$sim_status" -ne 0 ]; then
    echo "simulation failed with status $sim_status"
    exit "$sim_status"
fi

echo "simulation finished"
exit 0

// ==== verif/priv_unit_tb.sv ====
/*
 * testbench for the machine mode trap unit
 *   galois LFSR stimulus and CSR shadow model
 *   typed compare tasks
 *   CSR access, exception, interrupt, masking and return tests
 *   watchdog
 */
`timescale 1ns/1ps
`default_nettype none

`include "priv_config.svh"

module priv_unit_tb;

    import priv_types_pkg::*;

    // edges from a line change to trap_req
    localparam int SYNC_DELAY = `PRIV_SYNC_STAGES + 3;
    localparam int N_CSR  = 12;
    localparam int N_EXC  = 24;
    localparam int N_INT  = 12;
    localparam int N_MASK = 12;
    // rough cycle cost of each test
    localparam int TEST_CYCLES = 8 + N_CSR * 20 + N_EXC * 12
                               + N_INT * (24 + 2 * SYNC_DELAY)
                               + N_MASK * (8 + 2 * SYNC_DELAY);
    localparam int WATCHDOG_NS = (TEST_CYCLES + 100) * 4;
    localparam csr_addr_t CSR_LIST [7] = '{MSTATUS_ADDR, MIE_ADDR, MTVEC_ADDR, MEPC_ADDR,
                                           MCAUSE_ADDR, MTVAL_ADDR, MIP_ADDR};

    logic                  CLK;
    logic                  nRST;
    // {ext, soft, timer}
    logic [2:0]            irq_lines;
    // breakpoint down to fault_l, highest priority on the left
    logic [8:0]            ex_strobe;
    logic [`PRIV_XLEN-1:0] epc;
    logic [`PRIV_XLEN-1:0] tval;
    logic                  mret;
    logic                  pipe_clear;
    csr_addr_t             csr_addr;
    logic [`PRIV_XLEN-1:0] csr_wdata;
    logic                  csr_wen;
    logic                  csr_ren;
    logic                  trap_req;
    logic [`PRIV_XLEN-1:0] trap_vector;
    logic [`PRIV_XLEN-1:0] return_pc;
    logic [`PRIV_XLEN-1:0] csr_rdata;
    logic                  csr_illegal;

    // shadow CSRs
    mstatus_t              m_mstatus;
    mie_t                  m_mie;
    mip_t                  m_mip;
    mcause_t               m_mcause;
    logic [`PRIV_XLEN-1:0] m_mepc;
    logic [`PRIV_XLEN-1:0] m_mtval;
    logic [`PRIV_XLEN-1:0] m_mtvec;

    logic [15:0]           lfsr_state;
    string                 test_name;

    priv_unit dut0 (
        .CLK(CLK), .nRST(nRST),
        .ext_irq(irq_lines[2]), .soft_irq(irq_lines[1]), .timer_irq(irq_lines[0]),
        .breakpoint(ex_strobe[8]), .fault_insn_access(ex_strobe[7]),
        .illegal_insn(ex_strobe[6]), .mal_insn(ex_strobe[5]), .env_m(ex_strobe[4]),
        .mal_s(ex_strobe[3]), .mal_l(ex_strobe[2]), .fault_s(ex_strobe[1]),
        .fault_l(ex_strobe[0]),
        .epc(epc), .tval(tval), .mret(mret), .pipe_clear(pipe_clear),
        .csr_addr(csr_addr), .csr_wdata(csr_wdata), .csr_wen(csr_wen), .csr_ren(csr_ren),
        .trap_req(trap_req), .trap_vector(trap_vector), .return_pc(return_pc),
        .csr_rdata(csr_rdata), .csr_illegal(csr_illegal)
    );

    always #2 CLK = ~CLK;

    // 16-bit galois LFSR, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = {1'b0, lfsr_state[15:1]} ^ (lfsr_state[0] ? 16'hB400 : 16'h0000);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    // {ext, soft, timer} onto the meie, msie, mtie positions
    function automatic logic [`PRIV_XLEN-1:0] irq_word(input logic [2:0] v);
        logic [`PRIV_XLEN-1:0] w;
        w = '0;
        w[11] = v[2];
        w[3]  = v[1];
        w[7]  = v[0];
        return w;
    endfunction

    function automatic logic is_known(input csr_addr_t a);
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < 7; i++) begin
            hit = hit | (a == CSR_LIST[i]);
        end
        return hit;
    endfunction

    function automatic logic [30:0] top_exception(input logic [8:0] s);
        if (s[8]) return BREAKPOINT;
        if (s[7]) return INSN_ACCESS;
        if (s[6]) return ILLEGAL_INSN;
        if (s[5]) return INSN_MAL;
        if (s[4]) return ENV_CALL_M;
        if (s[3]) return S_ADDR_MAL;
        if (s[2]) return L_ADDR_MAL;
        if (s[1]) return S_FAULT;
        return L_FAULT;
    endfunction

    // pending and enabled set, external ranks first
    function automatic logic [30:0] top_interrupt(input logic [2:0] p);
        if (p[2]) return EXT_INT_M;
        if (p[1]) return SOFT_INT_M;
        return TIMER_INT_M;
    endfunction

    // core write through the field masks
    function automatic void model_write(input csr_addr_t a, input logic [`PRIV_XLEN-1:0] w);
        case (a)
            MSTATUS_ADDR: begin
                m_mstatus      = '0;
                m_mstatus.mie  = w[3];
                m_mstatus.mpie = w[7];
                m_mstatus.mpp  = w[12:11];
            end
            MIE_ADDR: begin
                m_mie      = '0;
                m_mie.msie = w[3];
                m_mie.mtie = w[7];
                m_mie.meie = w[11];
            end
            MIP_ADDR:    m_mip.msip = w[3];
            MTVEC_ADDR:  m_mtvec = {w[`PRIV_XLEN-1:2], 2'b00};
            MEPC_ADDR:   m_mepc = {w[`PRIV_XLEN-1:2], 2'b00};
            MCAUSE_ADDR: m_mcause = mcause_t'(w);
            MTVAL_ADDR:  m_mtval = w;
            default: ;
        endcase
    endfunction

    function automatic void model_trap(input logic intr, input logic [30:0] code,
                                       input logic [`PRIV_XLEN-1:0] pc,
                                       input logic [`PRIV_XLEN-1:0] tv);
        m_mcause.interrupt = intr;
        m_mcause.cause     = code;
        m_mepc             = {pc[`PRIV_XLEN-1:2], 2'b00};
        m_mtval            = tv;
        m_mstatus.mpie     = m_mstatus.mie;
        m_mstatus.mie      = 1'b0;
    endfunction

    function automatic void model_return();
        m_mstatus.mie  = m_mstatus.mpie;
        m_mstatus.mpie = 1'b0;
    endfunction

    task automatic abort_run();
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERROR %s %s: expected %b, actual %b", test_name, what, exp, act);
            abort_run();
        end
    endtask

    task automatic check_word(input string what, input logic [`PRIV_XLEN-1:0] exp,
                              input logic [`PRIV_XLEN-1:0] act);
        if (act !== exp) begin
            $display("ERROR %s %s: expected %h, actual %h", test_name, what, exp, act);
            abort_run();
        end
    endtask

    task automatic check_mstatus(input string what, input mstatus_t exp, input mstatus_t act);
        if (act !== exp) begin
            $display("ERROR %s %s: expected %h, actual %h", test_name, what, exp, act);
            abort_run();
        end
    endtask

    task automatic check_mcause(input string what, input mcause_t exp, input mcause_t act);
        if (act !== exp) begin
            $display("ERROR %s %s: expected %h, actual %h", test_name, what, exp, act);
            abort_run();
        end
    endtask

    // all bus tasks start and end on a falling edge
    task automatic csr_write(input csr_addr_t a, input logic [`PRIV_XLEN-1:0] w);
        csr_addr  = a;
        csr_wdata = w;
        csr_wen   = 1'b1;
        @(negedge CLK);
        csr_wen = 1'b0;
        model_write(a, w);
    endtask

    task automatic csr_read(input csr_addr_t a, output logic [`PRIV_XLEN-1:0] d,
                            output logic ill);
        csr_addr = a;
        csr_ren  = 1'b1;
        #1;
        d   = csr_rdata;
        ill = csr_illegal;
        @(negedge CLK);
        csr_ren = 1'b0;
    endtask

    // read one CSR against the model, plus the idle request and mtvec vector
    task automatic check_csr(input csr_addr_t a);
        logic [`PRIV_XLEN-1:0] d;
        logic                  ill;
        csr_read(a, d, ill);
        check_flag("csr_illegal", 1'b0, ill);
        check_flag("trap_req idle", 1'b0, trap_req);
        check_word("trap_vector", m_mtvec, trap_vector);
        case (a)
            MSTATUS_ADDR: check_mstatus("mstatus", m_mstatus, mstatus_t'(d));
            MCAUSE_ADDR:  check_mcause("mcause", m_mcause, mcause_t'(d));
            MIE_ADDR:     check_word("mie", m_mie, d);
            MIP_ADDR:     check_word("mip", m_mip, d);
            MTVEC_ADDR:   check_word("mtvec", m_mtvec, d);
            MEPC_ADDR:    check_word("mepc", m_mepc, d);
            default:      check_word("mtval", m_mtval, d);
        endcase
    endtask

    task automatic watch_trap(input int cycles, input logic exp);
        for (int k = 0; k < cycles; k++) begin
            @(negedge CLK);
            #1;
            check_flag("trap_req", exp, trap_req);
        end
    endtask

    task automatic do_mret();
        mret = 1'b1;
        @(negedge CLK);
        mret = 1'b0;
        model_return();
        check_csr(MSTATUS_ADDR);
        check_word("return_pc", m_mepc, return_pc);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        abort_run();
    end

    initial begin
        logic [31:0]           r;
        logic [`PRIV_XLEN-1:0] d;
        logic                  ill;
        logic [2:0]            en;
        logic [2:0]            lines;
        logic [2:0]            sel;
        logic                  global_off;
        logic [30:0]           code;
        csr_addr_t             addr;
        int                    hold;

        lfsr_state = 16'd62307;
        CLK        = 1'b0;
        nRST       = 1'b0;
        irq_lines  = '0;
        ex_strobe  = '0;
        epc        = '0;
        tval       = '0;
        mret       = 1'b0;
        pipe_clear = 1'b0;
        csr_addr   = '0;
        csr_wdata  = '0;
        csr_wen    = 1'b0;
        csr_ren    = 1'b0;
        m_mstatus  = '0;
        m_mie      = '0;
        m_mip      = '0;
        m_mtvec    = `PRIV_MTVEC_RESET;
        repeat (2) @(negedge CLK);
        nRST = 1'b1;

        test_name = "reset";
        check_csr(MSTATUS_ADDR);
        check_csr(MIE_ADDR);
        check_csr(MIP_ADDR);
        check_csr(MTVEC_ADDR);

        test_name = "csr_access";
        for (int i = 0; i < N_CSR; i++) begin
            csr_write(MSTATUS_ADDR, '0);
            csr_write(MIE_ADDR, rand_bits(32));
            csr_write(MIP_ADDR, rand_bits(32));
            r = rand_bits(32);
            // a written msip must not fire here
            if (m_mie.msie && m_mip.msip) begin
                r[3] = 1'b0;
            end
            csr_write(MSTATUS_ADDR, r);
            csr_write(MTVEC_ADDR, rand_bits(32));
            csr_write(MEPC_ADDR, rand_bits(32));
            csr_write(MCAUSE_ADDR, rand_bits(32));
            csr_write(MTVAL_ADDR, rand_bits(32));
            for (int a = 0; a < 7; a++) begin
                check_csr(CSR_LIST[a]);
            end
            r    = rand_bits(12);
            addr = r[11:0];
            if (is_known(addr)) begin
                addr = 12'h7c0;
            end
            csr_read(addr, d, ill);
            check_flag("csr_illegal on read", 1'b1, ill);
            csr_addr = addr;
            csr_wen  = 1'b1;
            #1;
            check_flag("csr_illegal on write", 1'b1, csr_illegal);
            @(negedge CLK);
            csr_wen = 1'b0;
        end
        csr_write(MIP_ADDR, '0);
        csr_write(MSTATUS_ADDR, '0);

        test_name = "exception";
        for (int i = 0; i < N_EXC; i++) begin
            csr_write(MSTATUS_ADDR, rand_bits(32));
            r         = rand_bits(9);
            ex_strobe = (r[8:0] == 9'd0) ? 9'h001 : r[8:0];
            epc       = rand_bits(32);
            tval      = rand_bits(32);
            code      = top_exception(ex_strobe);
            #1;
            check_flag("trap_req with strobe", 1'b1, trap_req);
            @(negedge CLK);
            ex_strobe = '0;
            model_trap(1'b0, code, epc,
                       (code == BREAKPOINT || code == ENV_CALL_M) ? '0 : tval);
            check_csr(MCAUSE_ADDR);
            check_csr(MEPC_ADDR);
            check_csr(MTVAL_ADDR);
            check_csr(MSTATUS_ADDR);
            do_mret();
        end

        test_name = "interrupt";
        for (int i = 0; i < N_INT; i++) begin
            r  = rand_bits(3);
            en = (r[2:0] == 3'd0) ? 3'b111 : r[2:0];
            r  = rand_bits(3);
            lines = r[2:0];
            if ((lines & en) == 3'd0) begin
                lines = lines | en;
            end
            csr_write(MIE_ADDR, irq_word(en));
            r    = rand_bits(32);
            r[3] = 1'b1;
            csr_write(MSTATUS_ADDR, r);
            epc       = rand_bits(32);
            irq_lines = lines;
            // request rises on the SYNC_DELAY-th edge exactly
            watch_trap(SYNC_DELAY - 1, 1'b0);
            r    = rand_bits(2);
            hold = int'(r[1:0]);
            watch_trap(1 + hold, 1'b1);
            m_mip = mip_t'(irq_word(lines));
            model_trap(1'b1, top_interrupt(lines & en), epc, '0);
            @(negedge CLK);
            pipe_clear = 1'b1;
            #1;
            check_flag("trap_req during pipe_clear", 1'b1, trap_req);
            @(negedge CLK);
            pipe_clear = 1'b0;
            #1;
            check_flag("trap_req after pipe_clear", 1'b0, trap_req);
            @(negedge CLK);
            check_csr(MCAUSE_ADDR);
            check_csr(MEPC_ADDR);
            check_csr(MTVAL_ADDR);
            check_csr(MSTATUS_ADDR);
            check_csr(MIP_ADDR);
            irq_lines = '0;
            repeat (SYNC_DELAY) @(negedge CLK);
            m_mip = '0;
            check_csr(MIP_ADDR);
            do_mret();
        end

        test_name = "masked_interrupt";
        for (int i = 0; i < N_MASK; i++) begin
            r   = rand_bits(2);
            sel = (r[1:0] == 2'd3) ? 3'b001 : (3'b001 << r[1:0]);
            r   = rand_bits(4);
            // global disable, or only the raised source disabled
            global_off = r[3];
            en = global_off ? r[2:0] : (r[2:0] & ~sel);
            csr_write(MIE_ADDR, irq_word(en));
            r    = rand_bits(32);
            r[3] = ~global_off;
            csr_write(MSTATUS_ADDR, r);
            irq_lines = sel;
            watch_trap(SYNC_DELAY, 1'b0);
            @(negedge CLK);
            m_mip = mip_t'(irq_word(sel));
            check_csr(MIP_ADDR);
            check_csr(MSTATUS_ADDR);
            irq_lines = '0;
            watch_trap(SYNC_DELAY, 1'b0);
            @(negedge CLK);
            m_mip = '0;
            check_csr(MIP_ADDR);
        end

        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== source/priv_unit.sv ====
/*
 * machine mode trap unit top level
 *   interrupt capture, trap handler, CSR file
 */
`timescale 1ns/1ps
`default_nettype none

`include "priv_config.svh"

module priv_unit (
    input  wire                         CLK,
    input  wire                         nRST,
    input  wire                         ext_irq, soft_irq, timer_irq,
    input  wire                         breakpoint, fault_insn_access, illegal_insn,
    input  wire                         mal_insn, env_m, mal_s, mal_l, fault_s, fault_l,
    input  wire  [`PRIV_XLEN-1:0]       epc,
    input  wire  [`PRIV_XLEN-1:0]       tval,
    input  wire                         mret,
    input  wire                         pipe_clear,
    input  wire  priv_types_pkg::csr_addr_t csr_addr,
    input  wire  [`PRIV_XLEN-1:0]       csr_wdata,
    input  wire                         csr_wen,
    input  wire                         csr_ren,
    output logic                        trap_req,
    output logic [`PRIV_XLEN-1:0]       trap_vector,
    output logic [`PRIV_XLEN-1:0]       return_pc,
    output logic [`PRIV_XLEN-1:0]       csr_rdata,
    output logic                        csr_illegal
);

    import priv_types_pkg::*;

    // capture to handler pulses
    logic set_ext, set_soft, set_timer;
    logic clr_ext, clr_soft, clr_timer;

    // CSR state seen by the handler
    mstatus_t curr_mstatus;
    mie_t     curr_mie;
    mip_t     curr_mip;

    // handler to CSR file writes
    logic                  inject_mstatus, inject_mip, inject_mcause;
    logic                  inject_mepc, inject_mtval;
    mstatus_t              next_mstatus;
    mip_t                  next_mip;
    mcause_t               next_mcause;
    logic [`PRIV_XLEN-1:0] next_mepc;
    logic [`PRIV_XLEN-1:0] next_mtval;

    // every port name matches its net
    priv_irq_capture irq_capture0 (.*);

    priv_trap_handler trap_handler0 (.*);

    priv_csr_file csr_file0 (.*);

endmodule

`default_nettype wire

// ==== source/priv_csr_file.sv ====
/*
 * machine trap CSR storage
 *   mstatus, mie, mip, mcause, mepc, mtval, mtvec
 *   write masks, inject over core write merge
 *   read mux, illegal address flag, trap and return vectors
 */
`timescale 1ns/1ps
`default_nettype none

`include "priv_config.svh"

module priv_csr_file (
    input  wire                         CLK,
    input  wire                         nRST,
    input  wire  priv_types_pkg::csr_addr_t csr_addr,
    input  wire  [`PRIV_XLEN-1:0]       csr_wdata,
    input  wire                         csr_wen,
    input  wire                         csr_ren,
    input  wire                         inject_mstatus,
    input  wire  priv_types_pkg::mstatus_t next_mstatus,
    input  wire                         inject_mip,
    input  wire  priv_types_pkg::mip_t  next_mip,
    input  wire                         inject_mcause,
    input  wire  priv_types_pkg::mcause_t next_mcause,
    input  wire                         inject_mepc,
    input  wire  [`PRIV_XLEN-1:0]       next_mepc,
    input  wire                         inject_mtval,
    input  wire  [`PRIV_XLEN-1:0]       next_mtval,
    output priv_types_pkg::mstatus_t    curr_mstatus,
    output priv_types_pkg::mie_t        curr_mie,
    output priv_types_pkg::mip_t        curr_mip,
    output logic [`PRIV_XLEN-1:0]       csr_rdata,
    output logic                        csr_illegal,
    output logic [`PRIV_XLEN-1:0]       trap_vector,
    output logic [`PRIV_XLEN-1:0]       return_pc
);

    import priv_types_pkg::*;

    // mpp, mpie and mie
    localparam logic [`PRIV_XLEN-1:0] MSTATUS_WMASK = `PRIV_XLEN'h1888;
    // meie, mtie and msie
    localparam logic [`PRIV_XLEN-1:0] MIE_WMASK     = `PRIV_XLEN'h0888;
    // msip only, meip and mtip come from the capture side
    localparam logic [`PRIV_XLEN-1:0] MIP_WMASK     = `PRIV_XLEN'h0008;
    localparam logic [`PRIV_XLEN-1:0] ALIGN_MASK    = {{(`PRIV_XLEN-2){1'b1}}, 2'b00};

    mstatus_t              mstatus_q;
    mie_t                  mie_q;
    mip_t                  mip_q;
    mcause_t               mcause_q;
    logic [`PRIV_XLEN-1:0] mepc_q;
    logic [`PRIV_XLEN-1:0] mtval_q;
    logic [`PRIV_XLEN-1:0] mtvec_q;
    logic                  wr_mstatus, wr_mie, wr_mip, wr_mtvec;
    logic                  wr_mepc, wr_mcause, wr_mtval;
    logic                  addr_ok;

    // core write decode
    assign wr_mstatus = csr_wen & (csr_addr == MSTATUS_ADDR);
    assign wr_mie     = csr_wen & (csr_addr == MIE_ADDR);
    assign wr_mip     = csr_wen & (csr_addr == MIP_ADDR);
    assign wr_mtvec   = csr_wen & (csr_addr == MTVEC_ADDR);
    assign wr_mepc    = csr_wen & (csr_addr == MEPC_ADDR);
    assign wr_mcause  = csr_wen & (csr_addr == MCAUSE_ADDR);
    assign wr_mtval   = csr_wen & (csr_addr == MTVAL_ADDR);

    // control CSRs, inject always beats the core port
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            mstatus_q <= '0;
            mie_q     <= '0;
            mip_q     <= '0;
            mtvec_q   <= `PRIV_MTVEC_RESET;
        end else begin
            if (inject_mstatus) begin
                mstatus_q <= mstatus_t'(next_mstatus & MSTATUS_WMASK);
            end else if (wr_mstatus) begin
                mstatus_q <= mstatus_t'(csr_wdata & MSTATUS_WMASK);
            end
            if (wr_mie) begin
                mie_q <= mie_t'(csr_wdata & MIE_WMASK);
            end
            if (inject_mip) begin
                mip_q <= next_mip;
            end else if (wr_mip) begin
                // keep the hardware pending bits, replace msip
                mip_q <= mip_t'((mip_q & ~MIP_WMASK) | (csr_wdata & MIP_WMASK));
            end
            if (wr_mtvec) begin
                mtvec_q <= csr_wdata & ALIGN_MASK;
            end
        end
    end

    // trap payload registers
    always_ff @(posedge CLK) begin
        if (inject_mcause) begin
            mcause_q <= next_mcause;
        end else if (wr_mcause) begin
            mcause_q <= mcause_t'(csr_wdata);
        end
        // mepc is always word aligned
        if (inject_mepc) begin
            mepc_q <= next_mepc & ALIGN_MASK;
        end else if (wr_mepc) begin
            mepc_q <= csr_wdata & ALIGN_MASK;
        end
        if (inject_mtval) begin
            mtval_q <= next_mtval;
        end else if (wr_mtval) begin
            mtval_q <= csr_wdata;
        end
    end

    // read mux, unknown addresses read zero
    always_comb begin
        addr_ok = 1'b1;
        case (csr_addr)
            MSTATUS_ADDR: csr_rdata = mstatus_q;
            MIE_ADDR:     csr_rdata = mie_q;
            MIP_ADDR:     csr_rdata = mip_q;
            MTVEC_ADDR:   csr_rdata = mtvec_q;
            MEPC_ADDR:    csr_rdata = mepc_q;
            MCAUSE_ADDR:  csr_rdata = mcause_q;
            MTVAL_ADDR:   csr_rdata = mtval_q;
            default: begin
                csr_rdata = '0;
                addr_ok   = 1'b0;
            end
        endcase
    end

    assign csr_illegal  = (csr_ren | csr_wen) & ~addr_ok;
    assign curr_mstatus = mstatus_q;
    assign curr_mie     = mie_q;
    assign curr_mip     = mip_q;
    // direct mode, every trap enters at mtvec
    assign trap_vector  = mtvec_q;
    assign return_pc    = mepc_q;

endmodule

`default_nettype wire

// ==== source/priv_trap_handler.sv ====
/*
 * trap decision logic
 *   exception and interrupt ranking
 *   trap entry and mret return
 *   next CSR values with their inject strobes
 */
`timescale 1ns/1ps
`default_nettype none

`include "priv_config.svh"

module priv_trap_handler (
    input  wire                       CLK,
    input  wire                       nRST,
    input  wire                       set_ext, set_soft, set_timer,
    input  wire                       clr_ext, clr_soft, clr_timer,
    input  wire                       breakpoint, fault_insn_access, illegal_insn,
    input  wire                       mal_insn, env_m, mal_s, mal_l, fault_s, fault_l,
    input  wire  [`PRIV_XLEN-1:0]     epc,
    input  wire  [`PRIV_XLEN-1:0]     tval,
    input  wire                       mret,
    input  wire                       pipe_clear,
    input  wire  priv_types_pkg::mstatus_t curr_mstatus,
    input  wire  priv_types_pkg::mie_t     curr_mie,
    input  wire  priv_types_pkg::mip_t     curr_mip,
    output logic                      trap_req,
    output logic                      inject_mstatus,
    output priv_types_pkg::mstatus_t  next_mstatus,
    output logic                      inject_mip,
    output priv_types_pkg::mip_t      next_mip,
    output logic                      inject_mcause,
    output priv_types_pkg::mcause_t   next_mcause,
    output logic                      inject_mepc,
    output logic [`PRIV_XLEN-1:0]     next_mepc,
    output logic                      inject_mtval,
    output logic [`PRIV_XLEN-1:0]     next_mtval
);

    import priv_types_pkg::*;

    ex_code_t  ex_src;
    int_code_t int_src;
    logic      exception;
    logic      interrupt_fired;
    // first cycle of a fired interrupt, the cycle the trap is taken
    logic      take_int;
    logic      interrupt_reg;
    logic      update_mie;
    logic      tval_cause;

    // exception ranking, breakpoint highest
    always_comb begin
        exception = 1'b1;
        ex_src    = INSN_MAL;
        if (breakpoint)             ex_src = BREAKPOINT;
        else if (fault_insn_access) ex_src = INSN_ACCESS;
        else if (illegal_insn)      ex_src = ILLEGAL_INSN;
        else if (mal_insn)          ex_src = INSN_MAL;
        else if (env_m)             ex_src = ENV_CALL_M;
        else if (mal_s)             ex_src = S_ADDR_MAL;
        else if (mal_l)             ex_src = L_ADDR_MAL;
        else if (fault_s)           ex_src = S_FAULT;
        else if (fault_l)           ex_src = L_FAULT;
        else                        exception = 1'b0;
    end

    // interrupt ranking over pending and enabled bits, timer is the fallback
    always_comb begin
        int_src = TIMER_INT_M;
        if (curr_mie.meie && curr_mip.meip)      int_src = EXT_INT_M;
        else if (curr_mie.msie && curr_mip.msip) int_src = SOFT_INT_M;
    end

    assign interrupt_fired = curr_mstatus.mie & ((curr_mie.meie & curr_mip.meip)
                                               | (curr_mie.msie & curr_mip.msip)
                                               | (curr_mie.mtie & curr_mip.mtip));
    assign take_int = interrupt_fired & ~update_mie;

    // exceptions raise the request at once, interrupts from the held flag
    assign trap_req = exception | interrupt_reg;

    // mip follows the capture pulses, set wins over clear
    assign inject_mip = set_ext | set_soft | set_timer | clr_ext | clr_soft | clr_timer;
    always_comb begin
        next_mip      = curr_mip;
        next_mip.meip = set_ext   | (curr_mip.meip & ~clr_ext);
        next_mip.msip = set_soft  | (curr_mip.msip & ~clr_soft);
        next_mip.mtip = set_timer | (curr_mip.mtip & ~clr_timer);
    end

    // trap entry stacks mie into mpie, mret pops it back
    assign inject_mstatus = exception | take_int | mret;
    always_comb begin
        next_mstatus = curr_mstatus;
        if (exception || take_int) begin
            next_mstatus.mpie = curr_mstatus.mie;
            next_mstatus.mie  = 1'b0;
        end else if (mret) begin
            next_mstatus.mie  = curr_mstatus.mpie;
            next_mstatus.mpie = 1'b0;
        end
    end

    // exception in the same cycle takes cause and epc
    assign inject_mcause = exception | take_int;
    always_comb begin
        next_mcause = '0;
        if (exception) begin
            next_mcause.cause = ex_src;
        end else begin
            next_mcause.interrupt = 1'b1;
            next_mcause.cause     = int_src;
        end
    end

    assign inject_mepc = exception | take_int;
    assign next_mepc   = epc;

    // breakpoint, ecall and interrupts leave mtval zero
    assign tval_cause   = exception & (ex_src != BREAKPOINT) & (ex_src != ENV_CALL_M);
    assign inject_mtval = exception | take_int;
    assign next_mtval   = tval_cause ? tval : '0;

    // mie drops right after entry, so hold the request until the flush ends
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            interrupt_reg <= 1'b0;
            update_mie    <= 1'b0;
        end else begin
            if (interrupt_fired) begin
                interrupt_reg <= 1'b1;
            end else if (pipe_clear) begin
                interrupt_reg <= 1'b0;
            end
            // one-cycle clip so mpie and mepc see a single write
            update_mie <= take_int;
        end
    end

endmodule

`default_nettype wire

// ==== source/priv_irq_capture.sv ====
/*
 * interrupt line capture
 *   synchronizer chain per request line
 *   registered rising and falling edge pulses
 */
`timescale 1ns/1ps
`default_nettype none

`include "priv_config.svh"

module priv_irq_capture (
    input  wire  CLK,
    input  wire  nRST,
    input  wire  ext_irq,
    input  wire  soft_irq,
    input  wire  timer_irq,
    output logic set_ext,
    output logic set_soft,
    output logic set_timer,
    output logic clr_ext,
    output logic clr_soft,
    output logic clr_timer
);

    // bit order everywhere here is {ext, soft, timer}
    logic [2:0] irq_in;
    logic [2:0] sync_q [`PRIV_SYNC_STAGES];
    logic [2:0] sync_out;
    // previous synchronized level, for edge detection
    logic [2:0] last_q;
    logic [2:0] set_q;
    logic [2:0] clr_q;

    assign irq_in   = {ext_irq, soft_irq, timer_irq};
    assign sync_out = sync_q[`PRIV_SYNC_STAGES-1];

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < `PRIV_SYNC_STAGES; i++) begin
                sync_q[i] <= '0;
            end
            last_q <= '0;
            set_q  <= '0;
            clr_q  <= '0;
        end else begin
            sync_q[0] <= irq_in;
            for (int i = 1; i < `PRIV_SYNC_STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
            last_q <= sync_out;
            // edges only, so a held line cannot re-set mip once software clears it
            set_q  <= sync_out & ~last_q;
            clr_q  <= ~sync_out & last_q;
        end
    end

    assign {set_ext, set_soft, set_timer} = set_q;
    assign {clr_ext, clr_soft, clr_timer} = clr_q;

endmodule

`default_nettype wire

// ==== source/priv_types_pkg.sv ====
/*
 * trap unit shared types
 *   mstatus, mie, mip and mcause field layouts
 *   exception and interrupt cause codes
 *   machine trap CSR addresses
 */
`default_nettype none

`include "priv_config.svh"

package priv_types_pkg;

    // machine status, only mie, mpie and mpp are implemented
    typedef struct packed {
        logic [`PRIV_XLEN-14:0] wpri_hi;
        logic [1:0]             mpp;
        logic [2:0]             wpri_10_8;
        logic                   mpie;
        logic [2:0]             wpri_6_4;
        logic                   mie;
        logic [2:0]             wpri_2_0;
    } mstatus_t;

    // machine interrupt enables
    typedef struct packed {
        logic [`PRIV_XLEN-13:0] zero_hi;
        logic                   meie;
        logic [2:0]             zero_10_8;
        logic                   mtie;
        logic [2:0]             zero_6_4;
        logic                   msie;
        logic [2:0]             zero_2_0;
    } mie_t;

    // machine interrupt pending, same bit positions as mie
    typedef struct packed {
        logic [`PRIV_XLEN-13:0] zero_hi;
        logic                   meip;
        logic [2:0]             zero_10_8;
        logic                   mtip;
        logic [2:0]             zero_6_4;
        logic                   msip;
        logic [2:0]             zero_2_0;
    } mip_t;

    // standard exception codes, supervisor and user causes not present
    typedef enum logic [30:0] {
        INSN_MAL     = 31'd0,
        INSN_ACCESS  = 31'd1,
        ILLEGAL_INSN = 31'd2,
        BREAKPOINT   = 31'd3,
        L_ADDR_MAL   = 31'd4,
        L_FAULT      = 31'd5,
        S_ADDR_MAL   = 31'd6,
        S_FAULT      = 31'd7,
        ENV_CALL_M   = 31'd11
    } ex_code_t;

    // machine level interrupt codes
    typedef enum logic [30:0] {
        SOFT_INT_M  = 31'd3,
        TIMER_INT_M = 31'd7,
        EXT_INT_M   = 31'd11
    } int_code_t;

    typedef struct packed {
        logic        interrupt;
        logic [30:0] cause;
    } mcause_t;

    typedef logic [11:0] csr_addr_t;

    localparam csr_addr_t MSTATUS_ADDR = 12'h300;
    localparam csr_addr_t MIE_ADDR     = 12'h304;
    localparam csr_addr_t MTVEC_ADDR   = 12'h305;
    localparam csr_addr_t MEPC_ADDR    = 12'h341;
    localparam csr_addr_t MCAUSE_ADDR  = 12'h342;
    localparam csr_addr_t MTVAL_ADDR   = 12'h343;
    localparam csr_addr_t MIP_ADDR     = 12'h344;

endpackage

`default_nettype wire

// ==== source/priv_config.svh ====
/*
 * trap unit configuration macros
 *   machine word width
 *   interrupt synchronizer depth
 *   handler address after reset
 */
`ifndef PRIV_CONFIG_SVH
`define PRIV_CONFIG_SVH

// machine word width, also the CSR width
`define PRIV_XLEN 32
// flops per interrupt line ahead of the edge detector
`define PRIV_SYNC_STAGES 2
// direct mode handler base, low two bits zero
`define PRIV_MTVEC_RESET 32'h0000_0100

`endif
